//--- design/sout_defines.svh
`ifndef SOUT_DEFINES_SVH
`define SOUT_DEFINES_SVH

// serial output word and address widths
`define SOUT_DATA_W 16
`define SOUT_ADDR_W 8

// cen cycles per output clock period (CKI / 12)
`define SOUT_CKDIV 12

// register field codes, 3 bits as in the r_field of the core
`define SOUT_RF_SIOC 3'd0
`define SOUT_RF_SRTA 3'd1
`define SOUT_RF_SDX  3'd2

`endif

//--- design/sio_reg_pkg.sv
`default_nettype none

`include "sout_defines.svh"

package sio_reg_pkg;

    // register selector from the instruction
    typedef logic [2:0] reg_field_t;

    // SIOC control word, bit 9 down to bit 0
    typedef struct packed {
        logic       frame_rate; // ILD/OLD and SYNC rate select
        logic [1:0] clk_sel;    // active clock = CKI / 12 when 01
        logic       msb_first;  // only bit acted upon
        logic       old_dir;    // out load direction
        logic       ild_dir;    // in load direction
        logic       ock_dir;    // out clock direction
        logic       ick_dir;    // in clock direction
        logic       out_width;  // 0 = 16-bit output
        logic       in_width;   // 0 = 16-bit input
    } sioc_fields_t;

    // one bus word, read as data for SRTA/SDX and as fields for SIOC
    typedef union packed {
        logic [`SOUT_DATA_W-1:0] word;
        struct packed {
            logic [5:0]   unused; // upper bits not stored in SIOC
            sioc_fields_t sioc;
        } ctl;
    } sio_word_u;

endpackage

`default_nettype wire

//--- design/reg_bus_pkg.sv
`default_nettype none

package reg_bus_pkg;

    // one write on the shared register bus, 19 bits
    typedef struct packed {
        sio_reg_pkg::reg_field_t field; // target register
        sio_reg_pkg::sio_word_u  data;
    } reg_wr_t;

    // what each writer presents to the arbiter, 20 bits
    typedef struct packed {
        logic    valid; // held until granted
        reg_wr_t wr;
    } reg_req_t;

endpackage

`default_nettype wire

//--- design/cpu_io_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "sout_defines.svh"

module cpu_io_port (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`SOUT_DATA_W-1:0]    long_imm,
    input  wire logic [`SOUT_DATA_W-1:0]    acc_dout,
    input  wire logic                       imm_load,
    input  wire logic                       acc_load,
    input  wire sio_reg_pkg::reg_field_t    r_field,
    input  wire logic                       grant,
    input  wire sio_reg_pkg::sioc_fields_t  sioc_q,
    input  wire logic [`SOUT_ADDR_W-1:0]    srta_q,
    output reg_bus_pkg::reg_req_t           req,
    output logic                            busy,
    output logic [`SOUT_DATA_W-1:0]         r_sio
);

    logic                 load;
    logic                 accept;  // new write taken into the request
    logic                 valid_q;
    reg_bus_pkg::reg_wr_t wr_q;    // pending write payload

    assign load   = imm_load | acc_load;
    assign accept = load & (~valid_q | grant); // slot free, or freed by this grant

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (grant) begin
            valid_q <= 1'b0; // served, drop at this edge
        end
    end

    // immediate wins over accumulator when both strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_q.field     <= r_field;
            wr_q.data.word <= imm_load ? long_imm : acc_dout;
        end
    end

    assign req.valid = valid_q;
    assign req.wr    = wr_q;
    assign busy      = valid_q & ~grant; // a write now would be lost

    // read back, serial input side not implemented
    always_comb begin
        case (r_field)
            `SOUT_RF_SIOC: r_sio = {6'd0, sioc_q};
            `SOUT_RF_SRTA: r_sio = {{(`SOUT_DATA_W-`SOUT_ADDR_W){1'b0}}, srta_q};
            default:       r_sio = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/host_io_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "sout_defines.svh"

module host_io_port (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     host_wr,
    input  wire sio_reg_pkg::reg_field_t  host_field,
    input  wire logic [`SOUT_DATA_W-1:0]  host_data,
    input  wire logic                     grant,
    output reg_bus_pkg::reg_req_t         req,
    output logic                          busy
);

    logic                 accept;
    logic                 valid_q;
    reg_bus_pkg::reg_wr_t wr_q;

    // only one write in flight, later ones are ignored until granted
    assign accept = host_wr & (~valid_q | grant);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (grant) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_q.field     <= host_field;
            wr_q.data.word <= host_data;
        end
    end

    assign req.valid = valid_q;
    assign req.wr    = wr_q;
    assign busy      = valid_q & ~grant; // still waiting past this cycle

endmodule

`default_nettype wire

//--- design/reg_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bus_arbiter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire reg_bus_pkg::reg_req_t  cpu_req,
    input  wire reg_bus_pkg::reg_req_t  host_req,
    output logic                        cpu_grant,
    output logic                        host_grant,
    output logic                        wr_en,
    output reg_bus_pkg::reg_wr_t        wr
);

    logic tie;
    logic last_cpu; // 1 when the cpu won the last tie

    assign tie = cpu_req.valid & host_req.valid;

    // lone requester goes through at once, ties alternate
    assign cpu_grant  = cpu_req.valid & (~host_req.valid | ~last_cpu);
    assign host_grant = host_req.valid & (~cpu_req.valid | last_cpu);

    // host counts as last winner out of reset, so the cpu takes the first tie
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_cpu <= 1'b0;
        end else if (tie) begin
            last_cpu <= cpu_grant;
        end
    end

    // forward the winner
    assign wr_en = cpu_grant | host_grant;
    assign wr    = cpu_grant ? cpu_req.wr : host_req.wr;

endmodule

`default_nettype wire

//--- design/serial_out.sv
`timescale 1ns/1ps
`default_nettype none

`include "sout_defines.svh"

module serial_out (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cen,
    input  wire logic                   wr_en,
    input  wire reg_bus_pkg::reg_wr_t   wr,
    output logic                        ock,     // serial output clock
    output logic                        sio_do,  // serial data
    output logic                        sadd,    // serial address
    output logic                        old,     // output load, low during frame
    output logic                        obe,     // output buffer empty
    output logic                        ibf,     // input buffer full, no input side
    output sio_reg_pkg::sioc_fields_t   sioc_q,
    output logic [`SOUT_ADDR_W-1:0]     srta_q
);

    localparam int CKDIV_W = $clog2(`SOUT_CKDIV);
    localparam logic [CKDIV_W-1:0] OCK_RISE = CKDIV_W'(`SOUT_CKDIV / 2 - 1);
    localparam logic [CKDIV_W-1:0] OCK_FALL = CKDIV_W'(`SOUT_CKDIV - 1);
    localparam logic [`SOUT_DATA_W:0] OCNT_EMPTY = {1'b1, {`SOUT_DATA_W{1'b0}}};
    localparam logic [`SOUT_DATA_W:0] OCNT_START = {{`SOUT_DATA_W{1'b0}}, 1'b1};

    logic [CKDIV_W-1:0]      clkdiv;
    logic                    last_ock;
    logic                    ock_rise;  // one pulse per ock rising edge
    logic                    sioc_wr;
    logic                    srta_wr;
    logic                    sdx_wr;
    logic                    shift_en;
    logic [`SOUT_DATA_W:0]   ocnt;      // one-hot bit position, top bit = empty
    logic [`SOUT_DATA_W-1:0] obuf;
    logic [`SOUT_ADDR_W-1:0] addr_buf;

    // register write decode
    assign sioc_wr = wr_en & (wr.field == `SOUT_RF_SIOC);
    assign srta_wr = wr_en & (wr.field == `SOUT_RF_SRTA);
    assign sdx_wr  = wr_en & (wr.field == `SOUT_RF_SDX);

    assign ock_rise = cen & ock & ~last_ock;
    // first rise of a frame only drops old, later ones shift
    assign shift_en = ock_rise & ~obe & ~old & ~sdx_wr;

    assign obe    = ocnt[`SOUT_DATA_W];
    assign sio_do = sioc_q.msb_first ? obuf[`SOUT_DATA_W-1] : obuf[0];
    assign sadd   = addr_buf[`SOUT_ADDR_W-1] & ~obe;
    assign ibf    = 1'b0;

    // divide cen by 12, ock runs only while there is data to send
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clkdiv   <= '0;
            ock      <= 1'b0;
            last_ock <= 1'b0;
        end else if (cen) begin
            clkdiv   <= (clkdiv == OCK_FALL) ? '0 : clkdiv + 1'b1;
            last_ock <= ock;
            if (clkdiv == OCK_RISE) ock <= ~obe;
            if (clkdiv == OCK_FALL) ock <= 1'b0;
        end
    end

    // control and address registers, written straight from the bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sioc_q <= '0;
            srta_q <= '0;
        end else begin
            if (sioc_wr) sioc_q <= wr.data.ctl.sioc; // field view of the word
            if (srta_wr) srta_q <= wr.data.word[`SOUT_ADDR_W-1:0];
        end
    end

    // frame state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ocnt <= OCNT_EMPTY;
            old  <= 1'b1;
        end else if (sdx_wr) begin
            // new word, a running frame starts over
            ocnt <= OCNT_START;
            old  <= 1'b1;
        end else if (ock_rise && !obe) begin
            old <= 1'b0;
            if (shift_en) ocnt <= ocnt << 1;
        end else if (cen && obe) begin
            old <= 1'b1; // frame done
        end
    end

    // shift registers for data and address
    always_ff @(posedge clk) begin
        if (sdx_wr) begin
            obuf     <= wr.data.word;
            addr_buf <= srta_q; // address latched with the data
        end else if (shift_en) begin
            obuf     <= sioc_q.msb_first ? obuf << 1 : obuf >> 1;
            addr_buf <= addr_buf << 1; // always MSB first
        end
    end

endmodule

`default_nettype wire

//--- design/dsp16_sout_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sout_defines.svh"

module dsp16_sout_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     cen,
    // cpu side
    input  wire logic [`SOUT_DATA_W-1:0]  long_imm,
    input  wire logic [`SOUT_DATA_W-1:0]  acc_dout,
    input  wire logic                     imm_load,
    input  wire logic                     acc_load,
    input  wire sio_reg_pkg::reg_field_t  r_field,
    // host side
    input  wire logic                     host_wr,
    input  wire sio_reg_pkg::reg_field_t  host_field,
    input  wire logic [`SOUT_DATA_W-1:0]  host_data,
    // serial pins
    output logic                          ock,
    output logic                          sio_do,
    output logic                          sadd,
    output logic                          old,
    output logic                          obe,
    output logic                          ibf,
    // status back to the writers
    output logic [`SOUT_DATA_W-1:0]       r_sio,
    output logic                          cpu_busy,
    output logic                          host_busy
);

    reg_bus_pkg::reg_req_t     cpu_req;
    reg_bus_pkg::reg_req_t     host_req;
    logic                      cpu_grant;
    logic                      host_grant;
    logic                      wr_en;
    reg_bus_pkg::reg_wr_t      wr;
    sio_reg_pkg::sioc_fields_t sioc_q;
    logic [`SOUT_ADDR_W-1:0]   srta_q;

    cpu_io_port u_cpu (
        .clk, .rst, .long_imm, .acc_dout, .imm_load, .acc_load, .r_field,
        .grant(cpu_grant), .sioc_q, .srta_q, .req(cpu_req), .busy(cpu_busy), .r_sio
    );

    host_io_port u_host (
        .clk, .rst, .host_wr, .host_field, .host_data,
        .grant(host_grant), .req(host_req), .busy(host_busy)
    );

    reg_bus_arbiter u_arb (
        .clk, .rst, .cpu_req, .host_req, .cpu_grant, .host_grant, .wr_en, .wr
    );

    serial_out u_sout (
        .clk, .rst, .cen, .wr_en, .wr,
        .ock, .sio_do, .sadd, .old, .obe, .ibf, .sioc_q, .srta_q
    );

endmodule

`default_nettype wire

//--- dv/sout_properties.sv
`timescale 1ns/1ps
`default_nettype none

module sout_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic cen,
    input wire logic old,
    input wire logic obe,
    input wire logic sadd,
    input wire logic cpu_grant,
    input wire logic host_grant
);

    // one writer at most owns the register bus
    grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cpu_grant, host_grant}))
        else $error("cpu and host granted in the same cycle");

    old_fall_loaded: assert property (@(posedge clk) disable iff (rst)
        $fell(old) |-> !obe) // frame opens only with a word loaded
        else $error("old fell while the output buffer was empty");

    // buffer empties only as the last shift ends, old still low then
    obe_rise_in_frame: assert property (@(posedge clk) disable iff (rst)
        $rose(obe) |-> !old)
        else $error("obe rose outside a shift frame");

    old_release: assert property (@(posedge clk) disable iff (rst)
        (obe && !old && cen) |=> old) // frame closes on the next cen
        else $error("old held low after the frame ended");

    sadd_idle: assert property (@(posedge clk) disable iff (rst)
        obe |-> !sadd)
        else $error("sadd high with the output buffer empty");

endmodule

// grants live between the arbiter and the serial unit, so watch from the top
bind dsp16_sout_top sout_properties u_props (
    .clk, .rst, .cen, .old, .obe, .sadd, .cpu_grant, .host_grant
);

`default_nettype wire

//--- dv/dsp16_sout_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sout_defines.svh"

module dsp16_sout_tb;

    localparam int NCOL      = 8;    // words per case line
    localparam int MAX_CASES = 64;
    localparam int WAIT_LIM  = 2000; // clocks before any wait gives up

    logic                      clk = 1'b0;
    logic                      cen = 1'b1;
    logic                      rst;
    logic [`SOUT_DATA_W-1:0]   long_imm;
    logic [`SOUT_DATA_W-1:0]   acc_dout;
    logic                      imm_load;
    logic                      acc_load;
    sio_reg_pkg::reg_field_t   r_field;
    logic                      host_wr;
    sio_reg_pkg::reg_field_t   host_field;
    logic [`SOUT_DATA_W-1:0]   host_data;
    logic                      ock;
    logic                      sio_do;
    logic                      sadd;
    logic                      old;
    logic                      obe;
    logic                      ibf;
    logic [`SOUT_DATA_W-1:0]   r_sio;
    logic                      cpu_busy;
    logic                      host_busy;

    logic [15:0]               cases_mem [0:NCOL*MAX_CASES-1];
    logic                      cen_half = 1'b0;  // cen on every other clock
    logic [31:0]               rng = 32'd69;
    logic                      model_msb = 1'b0; // msb_first after reset is 0
    logic [`SOUT_DATA_W-1:0]   model_sdx = '0;
    logic                      cpu_wins_tie = 1'b1;
    int                        value_errs = 0;
    int                        other_errs = 0;
    int                        timeouts = 0;
    // serial decoder state
    logic                      old_prev = 1'b1;
    logic                      ock_prev = 1'b0;
    logic [`SOUT_DATA_W-1:0]   dec_word = '0;
    logic [`SOUT_ADDR_W-1:0]   dec_addr = '0;
    int                        dec_count = 0;

    dsp16_sout_top uut (
        .clk, .rst, .cen, .long_imm, .acc_dout, .imm_load, .acc_load, .r_field,
        .host_wr, .host_field, .host_data,
        .ock, .sio_do, .sadd, .old, .obe, .ibf, .r_sio, .cpu_busy, .host_busy
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        #2;
        cen = cen_half ? ~cen : 1'b1;
    end

    // sample at negedge, away from the edge that moves ock and the data
    always @(negedge clk) begin
        old_prev <= old;
        ock_prev <= ock;
        if (!old && old_prev) begin
            dec_word  <= '0; // frame opened
            dec_addr  <= '0;
            dec_count <= 0;
        end else if (!old && ock && !ock_prev) begin
            dec_word <= {dec_word[`SOUT_DATA_W-2:0], sio_do}; // taken MSB first
            if (dec_count < `SOUT_ADDR_W) dec_addr <= {dec_addr[`SOUT_ADDR_W-2:0], sadd};
            dec_count <= dec_count + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [15:0] bit_reverse(input logic [15:0] d);
        logic [15:0] r;
        for (int i = 0; i < 16; i++) r[i] = d[15-i];
        return r;
    endfunction

    task automatic check_word(input string name, input sio_reg_pkg::sio_word_u got,
                              input sio_reg_pkg::sio_word_u exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got.word, exp.word);
            value_errs++;
        end
    endtask

    task automatic check_addr(input string name, input logic [`SOUT_ADDR_W-1:0] got,
                              input logic [`SOUT_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_read(input string name, input logic [`SOUT_DATA_W-1:0] got,
                              input logic [`SOUT_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        other_errs++;
    endtask

    task automatic wait_old(input logic level);
        int t = 0;
        while (old !== level && t < WAIT_LIM) begin
            @(negedge clk);
            t++;
        end
        if (old !== level) begin
            $display("timeout: old did not go to %0d within %0d clocks", level, WAIT_LIM);
            timeouts++;
        end
    endtask

    task automatic wait_ports_idle();
        int t = 0;
        while ((cpu_busy || host_busy) && t < WAIT_LIM) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (cpu_busy || host_busy) begin
            $display("timeout: a write port stayed busy for %0d clocks", WAIT_LIM);
            timeouts++;
        end
    endtask

    // expected register state after each write
    task automatic note_write(input sio_reg_pkg::reg_field_t f, input logic [15:0] d);
        if (f == `SOUT_RF_SIOC) model_msb = d[6];
        if (f == `SOUT_RF_SDX) model_sdx = d;
    endtask

    // called 2 ns after a rising edge, returns at the same point
    task automatic issue_writes(input logic cpu_on, input logic use_acc,
                                input sio_reg_pkg::reg_field_t cf, input logic [15:0] cd,
                                input logic host_on,
                                input sio_reg_pkg::reg_field_t hf, input logic [15:0] hd);
        r_field    = cf;
        long_imm   = use_acc ? ~cd : cd; // unselected source carries the complement
        acc_dout   = use_acc ? cd : ~cd;
        imm_load   = cpu_on & ~use_acc;
        acc_load   = cpu_on & use_acc;
        host_wr    = host_on;
        host_field = hf;
        host_data  = hd;
        @(posedge clk);
        #2;
        imm_load = 1'b0;
        acc_load = 1'b0;
        host_wr  = 1'b0;
        if (cpu_on && host_on) begin
            @(negedge clk); // tie cycle, the loser shows busy
            check_bit("cpu_busy", cpu_busy, ~cpu_wins_tie);
            check_bit("host_busy", host_busy, cpu_wins_tie);
            cpu_wins_tie = ~cpu_wins_tie; // ties alternate
        end
        wait_ports_idle();
        @(posedge clk);
        #2;
        if (cpu_on) note_write(cf, cd);
        if (host_on) note_write(hf, hd);
    endtask

    task automatic check_frame(input logic from_model, input logic [15:0] exp_w,
                               input logic [`SOUT_ADDR_W-1:0] exp_a);
        sio_reg_pkg::sio_word_u got;
        sio_reg_pkg::sio_word_u exp;
        wait_old(1'b0);
        if (timeouts != 0) return;
        wait_old(1'b1);
        if (timeouts != 0) return;
        got.word = dec_word;
        // lsb first shows up bit-reversed in an msb-first decode
        exp.word = from_model ? (model_msb ? model_sdx : bit_reverse(model_sdx)) : exp_w;
        check_word("sio_do word", got, exp);
        check_addr("sadd address", dec_addr, exp_a);
        check_bit("obe", obe, 1'b1);
        if (dec_count != 16) report_failure($sformatf("frame carried %0d bits, not 16", dec_count));
        @(posedge clk);
        #2;
    endtask

    task automatic watch_idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (!(old && obe && !ock)) begin
                report_failure("serial pins moved with no word written");
                break;
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic run_case(input int base);
        logic [3:0]              op;
        sio_reg_pkg::reg_field_t f1;
        sio_reg_pkg::reg_field_t f2;
        logic [15:0]             d1;
        logic [15:0]             d2;
        logic [15:0]             flags;
        op       = cases_mem[base][3:0];
        f1       = cases_mem[base+1][2:0];
        d1       = cases_mem[base+2];
        f2       = cases_mem[base+3][2:0];
        d2       = cases_mem[base+4];
        flags    = cases_mem[base+7];
        cen_half = flags[0];
        if (flags[1] && op <= 4'h2) begin
            rng = xorshift32(rng);
            d1  = rng[15:0];
        end
        case (op)
            4'h0: issue_writes(1'b1, 1'b0, f1, d1, 1'b0, f2, d2);
            4'h1: issue_writes(1'b1, 1'b1, f1, d1, 1'b0, f2, d2);
            4'h2: issue_writes(1'b0, 1'b0, f2, d2, 1'b1, f1, d1);
            4'h4: issue_writes(1'b1, 1'b0, f1, d1, 1'b1, f2, d2);
            4'h3: begin
                r_field = f1;
                @(negedge clk);
                check_read("r_sio", r_sio, cases_mem[base+5]);
                check_bit("ibf", ibf, 1'b0);
                @(posedge clk);
                #2;
            end
            4'h5: check_frame(flags[1], cases_mem[base+5], cases_mem[base+6][7:0]);
            4'h6: watch_idle(int'(d1));
            default: report_failure($sformatf("unknown op %h in case %0d", op, base / NCOL));
        endcase
    endtask

    initial begin
        int base;
        rst        = 1'b1;
        long_imm   = '0;
        acc_dout   = '0;
        imm_load   = 1'b0;
        acc_load   = 1'b0;
        r_field    = '0;
        host_wr    = 1'b0;
        host_field = '0;
        host_data  = '0;
        $readmemh("dv/sout_cases.txt", cases_mem);
        if ($isunknown(cases_mem[0])) report_failure("no cases read from dv/sout_cases.txt");
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int c = 0; c < MAX_CASES; c++) begin
            base = c * NCOL;
            if ($isunknown(cases_mem[base]) || cases_mem[base][3:0] == 4'hf) break;
            if (timeouts != 0) break;
            run_case(base);
        end
        $display("errors: %0d value, %0d other, %0d timeouts", value_errs, other_errs, timeouts);
        if (value_errs == 0 && other_errs == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dsp16_sout.f
+incdir+design
design/sio_reg_pkg.sv
design/reg_bus_pkg.sv
design/cpu_io_port.sv
design/host_io_port.sv
design/reg_bus_arbiter.sv
design/serial_out.sv
design/dsp16_sout_top.sv
dv/sout_properties.sv
dv/dsp16_sout_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, judge the run from its log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module dsp16_sout_tb \
    -Mdir obj_dir \
    -f dsp16_sout.f

./obj_dir/Vdsp16_sout_tb > sim.log
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished clean"

//--- dv/sout_cases.txt
// op field data field2 data2 exp_word exp_addr flags, all hex
// op: 0 cpu imm, 1 cpu acc, 2 host, 3 cpu read, 4 cpu+host together, 5 frame, 6 idle, f end
// flags: bit0 cen every other cycle, bit1 random write data (frame op: expect from last write)
6 0 0032 0 0000 0000 00 0
3 2 0000 0 0000 0000 00 0
3 5 0000 0 0000 0000 00 0
0 0 fe5a 0 0000 0000 00 0
3 0 0000 0 0000 025a 00 0
1 2 1234 0 0000 0000 00 0
5 0 0000 0 0000 1234 00 0
2 1 abc5 0 0000 0000 00 0
3 1 0000 0 0000 00c5 00 0
2 2 c3a5 0 0000 0000 00 1
5 0 0000 0 0000 c3a5 c5 1
0 0 0000 0 0000 0000 00 0
3 0 0000 0 0000 0000 00 0
0 2 1234 0 0000 0000 00 0
5 0 0000 0 0000 2c48 c5 0
4 1 005e 2 9001 0000 00 0
5 0 0000 0 0000 8009 5e 0
0 2 0000 0 0000 0000 00 2
5 0 0000 0 0000 0000 5e 2
4 0 0040 1 0033 0000 00 0
3 0 0000 0 0000 0040 00 0
3 1 0000 0 0000 0033 00 0
f 0 0000 0 0000 0000 00 0
